//--- all.f
burstPkg.sv
padPkg.sv
bucketFeeder.sv
padLane.sv
burstDrain.sv
pathCipher.sv
pathCipherTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the path cipher testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module pathCipherTb -f all.f -o pathCipherSim
./obj_dir/pathCipherSim | tee sim.log
grep -q "^Test OK$" sim.log

//--- pathCipherTb.sv
//--------------------------------------------------------------------
// Testbench for the path cipher: memory model, backend stimulus and
// assertions on data, round trip, stalls, phases and latency
//--------------------------------------------------------------------
`timescale 1ns/100ps

module pathCipherTb;
    import burstPkg::*;
    import padPkg::*;

    localparam int BucketBursts = 4;
    localparam int PathBuckets = 3;
    localparam int PadRounds = 3;
    localparam laneWordT Key = 32'h1F2E3D4C;
    localparam int Lanes = 4;
    localparam int PathBursts = BucketBursts * PathBuckets;
    // Four paths, up to four cycles per burst, plus drain margin
    localparam int TimeoutCycles = 4 * PathBursts * 4 + 100;

    logic Clock = 1'b0;
    logic rstN;
    burstT memRData, memWData, backWData, backRData;
    logic memRValid, memWValid, memWReady, backWValid, backWReady, backRValid;

    // Memory model contents and the last path written by the backend
    burstT memPath [PathBursts];
    burstT origPath [PathBursts];
    burstT readQ [$];
    burstT writeQ [$];
    burstT roundQ [$];
    int acceptQ [$];
    burstT readHead, writeHead, roundHead;
    bit readOk, writeOk, roundOk;
    int acceptHead;
    int cycleCount = 0;
    int inCount = 0;
    int outCount = 0;
    int wrCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    phaseT inPhase = PhaseRead;
    phaseT outPhase = PhaseRead;
    bit dropMode = 1'b0;

    pathCipher #(
        .BucketBursts(BucketBursts),
        .PathBuckets(PathBuckets),
        .PadRounds(PadRounds),
        .Key(Key),
        .Lanes(Lanes)
    ) dut (.*);

    always #2 Clock = ~Clock;

    // Expected burst: every lane XOR its pad, header IV left in clear
    function automatic burstT cipherBurst(burstT din, int idx, laneWordT iv);
        burstViewT view;
        seedT seed;
        laneWordT pad;
        view.payload = '0;
        for (int i = 0; i < Lanes; i++) begin
            seed = '{key: Key, iv: iv, burstIdx: 8'(idx), laneIdx: 8'(i)};
            pad = seedFold(seed);
            for (int r = 0; r < PadRounds; r++) begin
                pad = padRound(pad, Key);
            end
            view.payload[i*LaneWidth +: LaneWidth] = din[i*LaneWidth +: LaneWidth] ^ pad;
        end
        if (idx == 0) begin
            view.header.iv = iv;
        end
        return view.payload;
    endfunction

    //--------------------------------------------------------------------
    // Scoreboard and memory write side, updated at each edge
    //--------------------------------------------------------------------
    always @(posedge Clock) begin
        if (rstN) begin
            if (memRValid || (backWValid && backWReady)) begin
                acceptQ.push_back(cycleCount);
                inCount++;
                if (inCount % PathBursts == 0)
                    inPhase <= (inPhase == PhaseRead) ? PhaseWrite : PhaseRead;
            end
            if (backRValid || (memWValid && memWReady)) begin
                if (acceptQ.size() > 0)
                    void'(acceptQ.pop_front());
                outCount++;
                if (outCount % PathBursts == 0)
                    outPhase <= (outPhase == PhaseRead) ? PhaseWrite : PhaseRead;
            end
            if (backRValid && readQ.size() > 0)
                void'(readQ.pop_front());
            if (backRValid && roundQ.size() > 0)
                void'(roundQ.pop_front());
            if (memWValid && memWReady) begin
                if (writeQ.size() > 0)
                    void'(writeQ.pop_front());
                memPath[wrCount % PathBursts] = memWData;
                wrCount++;
            end
        end
        cycleCount <= cycleCount + 1;
        readOk <= readQ.size() > 0;
        readHead <= (readQ.size() > 0) ? readQ[0] : '0;
        writeOk <= writeQ.size() > 0;
        writeHead <= (writeQ.size() > 0) ? writeQ[0] : '0;
        roundOk <= roundQ.size() > 0;
        roundHead <= (roundQ.size() > 0) ? roundQ[0] : '0;
        acceptHead <= (acceptQ.size() > 0) ? acceptQ[0] : 0;
    end

    //--------------------------------------------------------------------
    // Checks
    //--------------------------------------------------------------------
    readCheck: assert property (@(posedge Clock) disable iff (!rstN)
        backRValid |-> (readOk && backRData == readHead))
        else begin
            valueErrors++;
            $display("** Error read: expected %h actual %h",
                $sampled(readHead), $sampled(backRData));
        end

    writeCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (memWValid && memWReady) |-> (writeOk && memWData == writeHead))
        else begin
            valueErrors++;
            $display("** Error write: expected %h actual %h",
                $sampled(writeHead), $sampled(memWData));
        end

    roundTripCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (backRValid && roundOk) |-> backRData == roundHead)
        else begin
            valueErrors++;
            $display("** Error round trip: expected %h actual %h",
                $sampled(roundHead), $sampled(backRData));
        end

    latencyCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (backRValid || (memWValid && memWReady && !dropMode))
        |-> (cycleCount - acceptHead == PadRounds + 1))
        else begin
            valueErrors++;
            $display("** Error latency: expected %0d actual %0d",
                PadRounds + 1, $sampled(cycleCount) - $sampled(acceptHead));
        end

    stallCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (memWValid && !memWReady) |=> (memWValid && $stable(memWData)))
        else begin
            otherErrors++;
            $display("Write burst changed or vanished while memory was stalled");
        end

    phaseCheck: assert property (@(posedge Clock) disable iff (!rstN)
        (inPhase == PhaseRead ? !backWReady : backWReady == !(memWValid && !memWReady))
        && (outPhase == PhaseRead ? !memWValid : !backRValid))
        else begin
            otherErrors++;
            $display("A strobe or ready was active in the wrong phase");
        end

    resetCheck: assert property (@(posedge Clock)
        !rstN |-> !(memWValid || backRValid || backWReady))
        else begin
            otherErrors++;
            $display("Output strobe active during reset");
        end

    //--------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------
    task automatic readPath();
        burstT word;
        laneWordT iv;
        for (int k = 0; k < PathBursts; k++) begin
            if ($urandom_range(0, 3) == 0) begin
                memRValid = 1'b0;
                @(posedge Clock);
                #0.5;
            end
            word = memPath[k];
            if (k % BucketBursts == 0)
                iv = word[IvWidth-1:0];
            readQ.push_back(cipherBurst(word, k % BucketBursts, iv));
            // Stored path came from the backend, so it must decrypt to the original
            if (wrCount > 0)
                roundQ.push_back(origPath[k]);
            memRData = word;
            memRValid = 1'b1;
            @(posedge Clock);
            #0.5;
        end
        memRValid = 1'b0;
    endtask

    task automatic writePath(input bit drops);
        burstT word;
        laneWordT iv;
        bit taken;
        dropMode = drops;
        for (int k = 0; k < PathBursts; k++) begin
            word = {$urandom, $urandom, $urandom, $urandom};
            if (k % BucketBursts == 0)
                iv = word[IvWidth-1:0];
            origPath[k] = word;
            writeQ.push_back(cipherBurst(word, k % BucketBursts, iv));
            backWData = word;
            backWValid = 1'b1;
            do begin
                if (drops)
                    memWReady = ($urandom_range(0, 2) != 0);
                #1;
                taken = backWReady;
                @(posedge Clock);
                #0.5;
            end while (!taken);
        end
        backWValid = 1'b0;
        memWReady = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h7869));
        rstN = 1'b0;
        memRData = '0;
        memRValid = 1'b0;
        memWReady = 1'b1;
        backWData = '0;
        backWValid = 1'b0;
        for (int k = 0; k < PathBursts; k++) begin
            memPath[k] = {$urandom, $urandom, $urandom, $urandom};
        end
        repeat (2) @(posedge Clock);
        #0.5;
        rstN = 1'b1;
        readPath();
        writePath(1'b0);
        // Next read path only once the whole write path is in memory
        do begin
            @(posedge Clock);
            #0.5;
        end while (wrCount < PathBursts);
        readPath();
        writePath(1'b1);
        do begin
            @(posedge Clock);
            #0.5;
        end while (wrCount < 2 * PathBursts || readQ.size() > 0);
        if (roundQ.size() != 0 || writeQ.size() != 0) begin
            otherErrors++;
            $display("Expected bursts never arrived at the outputs");
        end
        $display("Errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycleCount >= TimeoutCycles);
        $display("Timeout: run still busy after %0d cycles", cycleCount);
        $display("Errors: %0d wrong values, %0d other", valueErrors, otherErrors + 1);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- pathCipher.sv
//--------------------------------------------------------------------
// Counter-mode cipher layer between the ORAM backend and DRAM
// Decrypts read paths, encrypts write paths, alternating per path
//--------------------------------------------------------------------
`timescale 1ns/100ps

module pathCipher #(
    parameter int BucketBursts = 4,
    parameter int PathBuckets = 3,
    parameter int PadRounds = 3,
    parameter padPkg::laneWordT Key = 32'h1F2E3D4C,
    parameter int Lanes = 4
) (
    input  logic Clock,
    input  logic rstN,
    // Memory side
    input  burstPkg::burstT memRData,
    input  logic memRValid,
    output burstPkg::burstT memWData,
    output logic memWValid,
    input  logic memWReady,
    // Backend side
    input  burstPkg::burstT backWData,
    input  logic backWValid,
    output logic backWReady,
    output burstPkg::burstT backRData,
    output logic backRValid
);
    import burstPkg::*;
    import padPkg::*;

    seedT laneSeed [Lanes];
    laneWordT laneData [Lanes];
    laneWordT laneOut [Lanes];
    itemT feedItem;
    logic advance;

    if (Lanes > MaxLanes) begin : laneCheck
        $error("Lanes exceeds the burst lane count");
    end

    bucketFeeder #(
        .BucketBursts(BucketBursts),
        .PathBuckets(PathBuckets),
        .Lanes(Lanes),
        .Key(Key)
    ) feeder (
        .Clock(Clock),
        .rstN(rstN),
        .memRData(memRData),
        .memRValid(memRValid),
        .backWData(backWData),
        .backWValid(backWValid),
        .backWReady(backWReady),
        .advance(advance),
        .laneSeed(laneSeed),
        .laneData(laneData),
        .item(feedItem)
    );

    //--------------------------------------------------------------------
    // Keystream lanes
    //--------------------------------------------------------------------
    for (genvar i = 0; i < Lanes; i++) begin : laneGen
        padLane #(
            .PadRounds(PadRounds),
            .Key(Key)
        ) lane (
            .Clock(Clock),
            .rstN(rstN),
            .advance(advance),
            .seed(laneSeed[i]),
            .dataIn(laneData[i]),
            .dataOut(laneOut[i])
        );
    end

    burstDrain #(
        .PadRounds(PadRounds),
        .Lanes(Lanes)
    ) drain (
        .Clock(Clock),
        .rstN(rstN),
        .laneOut(laneOut),
        .item(feedItem),
        .memWData(memWData),
        .memWValid(memWValid),
        .memWReady(memWReady),
        .backRData(backRData),
        .backRValid(backRValid),
        .advance(advance)
    );

endmodule

//--- burstDrain.sv
//--------------------------------------------------------------------
// Back of the cipher pipeline: rebuilds bursts from lane words, puts
// the clear IV back into headers, routes by phase, drives advance
//--------------------------------------------------------------------
`timescale 1ns/100ps

module burstDrain #(
    parameter int PadRounds = 3,
    parameter int Lanes = 4
) (
    input  logic Clock,
    input  logic rstN,
    input  padPkg::laneWordT laneOut [Lanes],
    input  burstPkg::itemT item,
    output burstPkg::burstT memWData,
    output logic memWValid,
    input  logic memWReady,
    output burstPkg::burstT backRData,
    output logic backRValid,
    output logic advance
);
    import burstPkg::*;

    // Item delay line, one stage per lane round
    itemT itemPipe [PadRounds];
    itemT outItem;
    burstViewT outView;
    logic writeOut;
    logic readOut;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int s = 0; s < PadRounds; s++) begin
                itemPipe[s] <= '0;
            end
        end else if (advance) begin
            itemPipe[0] <= item;
            for (int s = 1; s < PadRounds; s++) begin
                itemPipe[s] <= itemPipe[s-1];
            end
        end
    end

    assign outItem = itemPipe[PadRounds-1];

    //--------------------------------------------------------------------
    // Reassembly
    //--------------------------------------------------------------------
    always_comb begin
        // Lanes above Lanes carry no data
        outView.payload = '0;
        for (int i = 0; i < Lanes; i++) begin
            outView.payload[i*LaneWidth +: LaneWidth] = laneOut[i];
        end
        // IV bits of a header were never meant to be ciphered
        if (outItem.header) begin
            outView.header.iv = outItem.iv;
        end
    end

    //--------------------------------------------------------------------
    // Routing and back-pressure
    //--------------------------------------------------------------------
    assign writeOut = outItem.valid && (outItem.phase == PhaseWrite);
    assign readOut = outItem.valid && (outItem.phase == PhaseRead);

    // Only a write burst waiting on the controller can stall; reads never do
    assign advance = !(writeOut && !memWReady);

    assign memWData = outView.payload;
    assign memWValid = writeOut;
    assign backRData = outView.payload;
    assign backRValid = readOut;

    // Frozen pipeline must present the same burst until memory takes it
    stallHold: assert property (@(posedge Clock) disable iff (!rstN)
        (memWValid && !memWReady) |=> (memWValid && $stable(memWData)))
        else $error("memWData changed while stalled");

endmodule

//--- padLane.sv
//--------------------------------------------------------------------
// One keystream lane: PadRounds registered mixing rounds, data slice
// carried alongside and XORed with the finished pad at the last stage
//--------------------------------------------------------------------
`timescale 1ns/100ps

module padLane #(
    parameter int PadRounds = 3,
    parameter padPkg::laneWordT Key = 32'h1F2E3D4C
) (
    input  logic Clock,
    input  logic rstN,
    input  logic advance,
    input  padPkg::seedT seed,
    input  padPkg::laneWordT dataIn,
    output padPkg::laneWordT dataOut
);
    import padPkg::*;

    // Pad state and matching data word per stage
    laneWordT padStage [PadRounds];
    laneWordT dataStage [PadRounds];

    //--------------------------------------------------------------------
    // Round pipeline
    //--------------------------------------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int s = 0; s < PadRounds; s++) begin
                padStage[s] <= '0;
                dataStage[s] <= '0;
            end
        end else if (advance) begin
            // First round works straight on the folded seed
            padStage[0] <= padRound(seedFold(seed), Key);
            dataStage[0] <= dataIn;
            for (int s = 1; s < PadRounds; s++) begin
                padStage[s] <= padRound(padStage[s-1], Key);
                dataStage[s] <= dataStage[s-1];
            end
        end
    end

    // Same operation encrypts and decrypts
    assign dataOut = dataStage[PadRounds-1] ^ padStage[PadRounds-1];

endmodule

//--- bucketFeeder.sv
//--------------------------------------------------------------------
// Front of the cipher pipeline: picks the input source by phase,
// tracks bucket and path position, captures the IV, issues lane seeds
//--------------------------------------------------------------------
`timescale 1ns/100ps

module bucketFeeder #(
    parameter int BucketBursts = 4,
    parameter int PathBuckets = 3,
    parameter int Lanes = 4,
    parameter padPkg::laneWordT Key = 32'h1F2E3D4C
) (
    input  logic Clock,
    input  logic rstN,
    input  burstPkg::burstT memRData,
    input  logic memRValid,
    input  burstPkg::burstT backWData,
    input  logic backWValid,
    output logic backWReady,
    input  logic advance,
    output padPkg::seedT laneSeed [Lanes],
    output padPkg::laneWordT laneData [Lanes],
    output burstPkg::itemT item
);
    import burstPkg::*;
    import padPkg::*;

    localparam int PathBursts = PathBuckets * BucketBursts;
    localparam int BktCntWidth = (BucketBursts > 1) ? $clog2(BucketBursts) : 1;
    localparam int PathCntWidth = (PathBursts > 1) ? $clog2(PathBursts) : 1;

    phaseT phase;
    logic [BktCntWidth-1:0] bktCnt;
    logic [PathCntWidth-1:0] pathCnt;
    logic [IvWidth-1:0] ivReg;
    logic [IvWidth-1:0] ivNow;
    burstViewT inView;
    logic take;
    logic isHeader;
    logic lastInBucket;
    logic lastInPath;

    // Backend may only push while writing and the drain is moving
    assign backWReady = (phase == PhaseWrite) && advance;
    assign take = advance && ((phase == PhaseRead) ? memRValid : backWValid);
    assign inView.payload = (phase == PhaseRead) ? memRData : backWData;

    assign isHeader = (bktCnt == '0);
    // Header burst uses its own IV, the rest of the bucket the captured one
    assign ivNow = isHeader ? inView.header.iv : ivReg;
    assign lastInBucket = (bktCnt == BktCntWidth'(BucketBursts - 1));
    assign lastInPath = (pathCnt == PathCntWidth'(PathBursts - 1));

    //--------------------------------------------------------------------
    // Position counters and direction
    //--------------------------------------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            phase <= PhaseRead;
            bktCnt <= '0;
            pathCnt <= '0;
        end else if (take) begin
            bktCnt <= lastInBucket ? '0 : bktCnt + 1'b1;
            pathCnt <= lastInPath ? '0 : pathCnt + 1'b1;
            if (lastInPath) begin
                phase <= (phase == PhaseRead) ? PhaseWrite : PhaseRead;
            end
        end
    end

    // IV capture for the remaining bursts of the bucket
    always_ff @(posedge Clock) begin
        if (take && isHeader) begin
            ivReg <= inView.header.iv;
        end
    end

    //--------------------------------------------------------------------
    // Stage register towards lanes and drain
    //--------------------------------------------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            item <= '0;
        end else if (advance) begin
            item.valid <= take;
            item.phase <= phase;
            item.header <= isHeader;
            item.iv <= ivNow;
        end
    end

    always_ff @(posedge Clock) begin
        if (advance) begin
            for (int i = 0; i < Lanes; i++) begin
                laneSeed[i] <= '{key: Key, iv: ivNow, burstIdx: 8'(bktCnt), laneIdx: 8'(i)};
                laneData[i] <= inView.payload[i*LaneWidth +: LaneWidth];
            end
        end
    end

    // Memory only returns bursts while a read path is open
    noReadInWrite: assert property (@(posedge Clock) disable iff (!rstN)
        !(memRValid && (phase == PhaseWrite)))
        else $error("memRValid high during write phase");

endmodule

//--- padPkg.sv
//--------------------------------------------------------------------
// Keystream seed format and the round function of the pad pipeline
// Also used by the testbench to rebuild expected pads
//--------------------------------------------------------------------
package padPkg;

    typedef logic [31:0] laneWordT;

    // Everything a lane needs to derive its pad word
    typedef struct packed {
        laneWordT key;
        laneWordT iv;
        // Burst position within the bucket
        logic [7:0] burstIdx;
        logic [7:0] laneIdx;
    } seedT;

    // Odd multiplier, so each round is a bijection before the key XOR
    localparam laneWordT MixMult = 32'h9E3779B1;
    localparam int MixRot = 13;

    //--------------------------------------------------------------------
    // Seed to 32-bit starting state
    //--------------------------------------------------------------------
    function automatic laneWordT seedFold(seedT s);
        return s.key ^ s.iv ^ {s.burstIdx, 8'h00, s.laneIdx, 8'h5A};
    endfunction

    // One mixing round: multiply, rotate left, XOR key
    function automatic laneWordT padRound(laneWordT state, laneWordT key);
        laneWordT prod;
        prod = state * MixMult;
        return {prod[31-MixRot:0], prod[31:32-MixRot]} ^ key;
    endfunction

    // Pad of a lane is padRound applied PadRounds times to seedFold(seed)

endpackage

//--- burstPkg.sv
//--------------------------------------------------------------------
// Burst layout shared by the cipher datapath and its testbench
// Import wherever burst words, header views or pipeline items are used
//--------------------------------------------------------------------
package burstPkg;

    //--------------------------------------------------------------------
    // Widths
    //--------------------------------------------------------------------
    localparam int LaneWidth = 32;
    localparam int MaxLanes = 4;
    localparam int BurstWidth = LaneWidth * MaxLanes;
    // IV sits in the low bits of burst 0 of every bucket
    localparam int IvWidth = 32;

    typedef logic [BurstWidth-1:0] burstT;

    // Two readings of the same burst word
    typedef union packed {
        burstT payload;
        struct packed {
            logic [BurstWidth-IvWidth-1:0] upper;
            logic [IvWidth-1:0] iv;
        } header;
    } burstViewT;

    // Transfer direction of the current path
    typedef enum logic {
        PhaseRead = 1'b0,
        PhaseWrite = 1'b1
    } phaseT;

    //--------------------------------------------------------------------
    // Side information that travels with each burst
    //--------------------------------------------------------------------
    typedef struct packed {
        phaseT phase;
        // First burst of its bucket
        logic header;
        // Clear IV of the bucket this burst belongs to
        logic [IvWidth-1:0] iv;
        logic valid;
    } itemT;

endpackage
